// File: src/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// state of the address tenure as the memory target counts it
	typedef enum logic [1:0] {
		addr_idle,
		addr_delay,
		addr_aack_wait,
		addr_aack
	} addr_state_t;

	// states of one processor's bus sequencer
	typedef enum logic [2:0] {
		m_idle,
		m_areq,
		m_ts,
		m_aack,
		m_gap,
		m_dreq,
		m_data
	} master_state_t;

	// which processor owns a bus
	typedef enum logic {
		cpu1,
		cpu2
	} cpu_id_t;

	// transfer type of a snoop push, which is never snooped itself
	localparam logic [4:0] tt_snoop_push = 5'b00110;

	// every data tenure is a fixed burst
	localparam int burst_beats = 4;

	// cycles from TS_ before AACK_ or a held TA_ may be asserted
	localparam int aack_min_delay = 3;

	// any nonzero value works as the LFSR start point
	localparam logic [15:0] lfsr_seed = 16'hace1;

endpackage

`default_nettype wire

// File: src/choice_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module choice_lfsr import bus_pkg::*; (
	input wire clk,
	input wire reset,
	output logic stall_aack,
	output logic ta_choice,
	output logic drtry_choice
);

	logic [15:0] q;
	logic feedback;

	// taps 16 15 13 4 give the full 65535 cycle sequence
	assign feedback = q[15] ^ q[14] ^ q[12] ^ q[3];

	always_ff @(posedge clk) begin
		if (reset)
			q <= lfsr_seed;
		else
			q <= {q[14:0], feedback};
	end

	// TA_ is offered most cycles, DRTRY_ only now and then
	assign stall_aack = q[15];
	assign ta_choice = q[10] | q[4];
	assign drtry_choice = q[1] & q[12];

endmodule

`default_nettype wire

// File: src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import bus_pkg::*; (
	input wire clk,
	input wire reset,
	input wire abr1_,
	input wire abr2_,
	input wire dbr1_,
	input wire dbr2_,
	input wire ts_,
	input wire dbb_,
	output logic bg1_,
	output logic bg2_,
	output logic dbg1_,
	output logic dbg2_
);

	// the pointer breaks a tie, a lone requester always wins
	function automatic cpu_id_t rr_pick(input logic want1, input logic want2, input cpu_id_t ptr);
		if (want1 && want2)
			return ptr;
		return want1 ? cpu1 : cpu2;
	endfunction

	logic a_busy;
	logic d_busy;
	logic a_owner_req;
	cpu_id_t a_owner;
	cpu_id_t a_ptr;
	cpu_id_t d_ptr;
	cpu_id_t a_pick;
	cpu_id_t d_pick;

	assign a_pick = rr_pick(!abr1_, !abr2_, a_ptr);
	assign d_pick = rr_pick(!dbr1_, !dbr2_, d_ptr);

	// the owner keeps its request up until AACK_, so this marks the open address tenure
	assign a_owner_req = (a_owner == cpu1) ? !abr1_ : !abr2_;

	// address bus: grant, drop the grant on TS_, then wait for the tenure to close
	always_ff @(posedge clk) begin
		if (reset) begin
			bg1_ <= 1'b1;
			bg2_ <= 1'b1;
			a_busy <= 1'b0;
			a_owner <= cpu1;
			a_ptr <= cpu1;
		end else if (!a_busy) begin
			if (!abr1_ || !abr2_) begin
				a_busy <= 1'b1;
				a_owner <= a_pick;
				bg1_ <= (a_pick != cpu1);
				bg2_ <= (a_pick != cpu2);
				// the other master is favored next time
				a_ptr <= (a_pick == cpu1) ? cpu2 : cpu1;
			end
		end else if (!bg1_ || !bg2_) begin
			if (!ts_) begin
				bg1_ <= 1'b1;
				bg2_ <= 1'b1;
			end
		end else if (!a_owner_req) begin
			a_busy <= 1'b0;
		end
	end

	// data bus: the grant goes away once DBB_ is taken, the bus frees when DBB_ rises
	always_ff @(posedge clk) begin
		if (reset) begin
			dbg1_ <= 1'b1;
			dbg2_ <= 1'b1;
			d_busy <= 1'b0;
			d_ptr <= cpu1;
		end else if (!d_busy) begin
			// a retried beat may bring DBB_ back, so never grant over it
			if (dbb_ && (!dbr1_ || !dbr2_)) begin
				d_busy <= 1'b1;
				dbg1_ <= (d_pick != cpu1);
				dbg2_ <= (d_pick != cpu2);
				d_ptr <= (d_pick == cpu1) ? cpu2 : cpu1;
			end
		end else if (!dbg1_ || !dbg2_) begin
			if (!dbb_) begin
				dbg1_ <= 1'b1;
				dbg2_ <= 1'b1;
			end
		end else if (dbb_) begin
			d_busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: src/bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module bus_master import bus_pkg::*; (
	input wire clk,
	input wire reset,
	input wire req,
	input wire [4:0] tt_in,
	input wire gbl_in,
	input wire bg_,
	input wire dbg_,
	input wire aack_,
	input wire artry_,
	input wire ta_,
	input wire drtry_,
	output logic abr_,
	output logic dbr_,
	output logic ts,
	output logic [4:0] tt,
	output logic gbl_,
	output logic dbb,
	output logic done
);

	master_state_t state;
	logic [4:0] tt_q;
	logic gbl_q;
	logic artry_seen;
	logic [2:0] beats;
	logic ta_q;
	logic in_addr;
	logic ta_hit;
	logic retract;
	logic finish;

	// the address tenure runs from the TS cycle to the AACK cycle
	assign in_addr = (state == m_ts) || (state == m_aack);
	assign ta_hit = (state == m_data) && !ta_;
	// DRTRY_ right after our TA_ takes that beat back
	assign retract = ta_q && !drtry_;
	// the last beat only counts once DRTRY_ stays negated behind it
	assign finish = ta_q && drtry_ && (beats == 3'(burst_beats));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= m_idle;
			artry_seen <= 1'b0;
			beats <= 3'd0;
			ta_q <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			ta_q <= ta_hit && !finish;
			case (state)
			m_idle: if (req) state <= m_areq;
			m_areq: if (!bg_) state <= m_ts;
			m_ts: state <= m_aack;
			m_aack: if (!aack_) state <= (artry_seen || !artry_) ? m_gap : m_dreq;
			// one cycle with the request down lets the arbiter rotate
			m_gap: state <= m_areq;
			m_dreq: if (!dbg_) begin
				state <= m_data;
				beats <= 3'd0;
			end
			m_data: if (finish) begin
				state <= m_idle;
				done <= 1'b1;
			end else begin
				beats <= beats + {2'b00, ta_hit} - {2'b00, retract};
			end
			default: state <= m_idle;
			endcase
			// any ARTRY_ inside the tenure forces a new one
			if (in_addr && !artry_)
				artry_seen <= 1'b1;
			if (state == m_aack && !aack_)
				artry_seen <= 1'b0;
		end
	end

	// command attributes are held for the retries too
	always_ff @(posedge clk) begin
		if (state == m_idle && req) begin
			tt_q <= tt_in;
			gbl_q <= gbl_in;
		end
	end

	assign abr_ = !((state == m_areq) || in_addr);
	assign ts = (state != m_ts);
	assign tt = in_addr ? tt_q : 5'd0;
	// a snoop push goes out non-global so the target does not hold TA_
	assign gbl_ = !(in_addr && gbl_q && (tt_q != tt_snoop_push));
	assign dbr_ = (state != m_dreq);
	assign dbb = (state != m_data);

endmodule

`default_nettype wire

// File: src/mem_target.sv
`timescale 1ns/1ps
`default_nettype none

module mem_target import bus_pkg::*; (
	input wire clk,
	input wire reset,
	input wire ts_,
	input wire [4:0] tt,
	input wire gbl_,
	input wire artry_,
	input wire dbb_,
	input wire bg1_,
	input wire bg2_,
	input wire dbg1_,
	input wire stall_aack,
	input wire ta_choice,
	input wire drtry_choice,
	output logic aack_,
	output logic ta_,
	output logic drtry_
);

	addr_state_t addr_state;
	logic hold_ta;
	cpu_id_t next_addr_master;
	cpu_id_t addr_master_q;
	cpu_id_t addr_master;
	cpu_id_t data_master;
	logic valid_artry;
	logic must_delay_ta;
	logic ta_reg_;

	// AACK_ may come no sooner than aack_min_delay cycles after TS_
	// the count is idle, delay, then aack_wait which may stall before aack
	// hold_ta covers the same window so a TA_ on the same tenure is not early
	// a snoop push is never snooped, so it leaves hold_ta alone
	always_ff @(posedge clk) begin
		if (reset) begin
			addr_state <= addr_idle;
			hold_ta <= 1'b0;
		end else begin
			case (addr_state)
			addr_idle: if (!ts_) begin
				addr_state <= addr_delay;
				if (tt != tt_snoop_push)
					hold_ta <= 1'b1;
			end
			addr_delay: addr_state <= addr_aack_wait;
			addr_aack_wait: begin
				// this is the first cycle AACK_ could have come, so TA_ is free now
				hold_ta <= 1'b0;
				addr_state <= stall_aack ? addr_aack_wait : addr_aack;
			end
			addr_aack: addr_state <= addr_idle;
			default: addr_state <= addr_idle;
			endcase
		end
	end

	assign aack_ = (addr_state == addr_aack) ? 1'b0 : 1'b1;

	// the last grant seen tells who drives the next TS_
	always_ff @(posedge clk) begin
		if (reset)
			next_addr_master <= cpu1;
		else if (!bg1_)
			next_addr_master <= cpu1;
		else if (!bg2_)
			next_addr_master <= cpu2;
	end

	// the address master is whoever last asserted TS_, including the TS_ cycle
	always_ff @(posedge clk) begin
		if (reset)
			addr_master_q <= cpu1;
		else if (!ts_)
			addr_master_q <= next_addr_master;
	end

	assign addr_master = !ts_ ? next_addr_master : addr_master_q;

	// the data master is sampled from the grant until DBB_ is taken
	always_ff @(posedge clk) begin
		if (reset)
			data_master <= cpu1;
		else if (dbb_)
			data_master <= !dbg1_ ? cpu1 : cpu2;
	end

	// with split buses an ARTRY_ only matters to the tenure whose data is on the bus
	assign valid_artry = !artry_ && (data_master == addr_master);

	// when the address tenure of another master runs, its snoop window already
	// gives enough delay, so only the same master has to wait
	assign must_delay_ta = (data_master == addr_master) && hold_ta && !gbl_;

	// TA_ only inside a data tenure, which DRTRY_ keeps open
	assign ta_ = ((!dbb_ || !drtry_) && !valid_artry && !must_delay_ta) ? ta_reg_ : 1'b1;

	always_ff @(posedge clk) begin
		if (reset)
			ta_reg_ <= 1'b1;
		else
			ta_reg_ <= !ta_choice;
	end

	// DRTRY_ may only follow a TA_, and once low it stays low until the next TA_
	// the transfer type is ignored here even though writes never see DRTRY_
	always_ff @(posedge clk) begin
		if (reset)
			drtry_ <= 1'b1;
		else if (valid_artry)
			drtry_ <= 1'b1;
		else if (!ta_)
			drtry_ <= !drtry_choice;
		else if (!drtry_)
			drtry_ <= 1'b0;
		else
			drtry_ <= 1'b1;
	end

endmodule

`default_nettype wire

// File: src/bus_top.sv
`timescale 1ns/1ps
`default_nettype none

module bus_top (
	input wire clk,
	input wire reset,
	input wire cpu1_req,
	input wire [4:0] cpu1_tt,
	input wire cpu1_gbl,
	input wire cpu2_req,
	input wire [4:0] cpu2_tt,
	input wire cpu2_gbl,
	input wire artry_,
	output wire cpu1_done,
	output wire cpu2_done,
	output wire ts_,
	output wire [4:0] tt,
	output wire gbl_,
	output wire aack_,
	output wire ta_,
	output wire drtry_,
	output wire dbb_,
	output wire bg1_,
	output wire bg2_,
	output wire dbg1_
);

	wire abr1_;
	wire abr2_;
	wire dbr1_;
	wire dbr2_;
	wire dbg2_;
	wire m1_ts;
	wire m2_ts;
	wire [4:0] m1_tt;
	wire [4:0] m2_tt;
	wire m1_gbl_;
	wire m2_gbl_;
	wire m1_dbb;
	wire m2_dbb;
	wire stall_aack;
	wire ta_choice;
	wire drtry_choice;

	// open drain bus lines, any master pulling low wins
	assign ts_ = m1_ts & m2_ts;
	assign dbb_ = m1_dbb & m2_dbb;
	assign gbl_ = m1_gbl_ & m2_gbl_;
	// an idle master drives zero on TT
	assign tt = m1_tt | m2_tt;

	bus_arbiter i_arbiter (
		.clk(clk), .reset(reset),
		.abr1_(abr1_), .abr2_(abr2_), .dbr1_(dbr1_), .dbr2_(dbr2_),
		.ts_(ts_), .dbb_(dbb_),
		.bg1_(bg1_), .bg2_(bg2_), .dbg1_(dbg1_), .dbg2_(dbg2_)
	);

	bus_master i_master1 (
		.clk(clk), .reset(reset),
		.req(cpu1_req), .tt_in(cpu1_tt), .gbl_in(cpu1_gbl),
		.bg_(bg1_), .dbg_(dbg1_), .aack_(aack_), .artry_(artry_),
		.ta_(ta_), .drtry_(drtry_),
		.abr_(abr1_), .dbr_(dbr1_), .ts(m1_ts), .tt(m1_tt), .gbl_(m1_gbl_),
		.dbb(m1_dbb), .done(cpu1_done)
	);

	bus_master i_master2 (
		.clk(clk), .reset(reset),
		.req(cpu2_req), .tt_in(cpu2_tt), .gbl_in(cpu2_gbl),
		.bg_(bg2_), .dbg_(dbg2_), .aack_(aack_), .artry_(artry_),
		.ta_(ta_), .drtry_(drtry_),
		.abr_(abr2_), .dbr_(dbr2_), .ts(m2_ts), .tt(m2_tt), .gbl_(m2_gbl_),
		.dbb(m2_dbb), .done(cpu2_done)
	);

	choice_lfsr i_lfsr (
		.clk(clk), .reset(reset),
		.stall_aack(stall_aack), .ta_choice(ta_choice), .drtry_choice(drtry_choice)
	);

	mem_target i_target (
		.clk(clk), .reset(reset),
		.ts_(ts_), .tt(tt), .gbl_(gbl_), .artry_(artry_), .dbb_(dbb_),
		.bg1_(bg1_), .bg2_(bg2_), .dbg1_(dbg1_),
		.stall_aack(stall_aack), .ta_choice(ta_choice), .drtry_choice(drtry_choice),
		.aack_(aack_), .ta_(ta_), .drtry_(drtry_)
	);

endmodule

`default_nettype wire

// File: test/bus_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bus_checker import bus_pkg::*; (
	input wire clk,
	input wire reset,
	input wire ts_,
	input wire [4:0] tt,
	input wire gbl_,
	input wire aack_,
	input wire artry_,
	input wire ta_,
	input wire drtry_,
	input wire dbb_,
	input wire bg1_,
	input wire bg2_,
	input wire dbg1_,
	input wire cpu1_done,
	input wire cpu2_done,
	input wire cmd_active,
	input wire cmd_cpu,
	input wire [4:0] exp_tt,
	input wire exp_gbl_,
	input wire [31:0] exp_beats,
	input wire [31:0] exp_ts,
	output logic [31:0] errors
);

	// bus ownership as seen from the grants, TS_ and DBB_
	cpu_id_t next_a;
	cpu_id_t a_owner_q;
	cpu_id_t d_owner;
	int since_ts;
	logic addr_open;
	logic global_ts;
	logic prev_ta_low;
	logic prev_dbb_low;
	logic prev_drtry_low;
	logic prev_valid_artry;
	int beats [2];
	int ts_seen [2];

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("mismatch %s at %0t: got 0x%0h, expected 0x%0h", name, $time, got, want);
		errors = errors + 1;
	endtask

	task automatic report_event(input string what);
		$display("error at %0t: %s", $time, what);
		errors = errors + 1;
	endtask

	always @(posedge clk) begin
		cpu_id_t a_owner;
		cpu_id_t done_cpu;
		logic valid_artry;
		if (reset) begin
			next_a = cpu1;
			a_owner_q = cpu1;
			d_owner = cpu1;
			since_ts = 255;
			addr_open = 1'b0;
			global_ts = 1'b0;
			prev_ta_low = 1'b0;
			prev_dbb_low = 1'b0;
			prev_drtry_low = 1'b0;
			prev_valid_artry = 1'b0;
			beats[0] = 0;
			beats[1] = 0;
			ts_seen[0] = 0;
			ts_seen[1] = 0;
			errors = 0;
		end else begin
			// the TS_ cycle already belongs to the newly granted master
			a_owner = !ts_ ? next_a : a_owner_q;
			// ARTRY_ only counts when one master owns both buses
			valid_artry = !artry_ && (a_owner == d_owner);
			if (!ts_)
				since_ts = 0;
			else if (since_ts < 255)
				since_ts = since_ts + 1;

			// every TS_ opens a tenure that exactly one AACK_ closes
			if (!ts_) begin
				if (addr_open)
					report_event("ts_ asserted while the previous address tenure was open");
				addr_open = 1'b1;
				global_ts = !gbl_ && (tt != tt_snoop_push);
				ts_seen[a_owner] = ts_seen[a_owner] + 1;
				// the TS_ cycle carries the transfer attributes of the running command
				if (cmd_active && tt != exp_tt)
					report_value("tt", 32'(tt), 32'(exp_tt));
				if (cmd_active && gbl_ != exp_gbl_)
					report_value("gbl_", 32'(gbl_), 32'(exp_gbl_));
			end
			if (!aack_) begin
				if (!addr_open)
					report_event("aack_ asserted without an open address tenure");
				else if (since_ts < aack_min_delay)
					report_value("aack_ delay", since_ts, aack_min_delay);
				addr_open = 1'b0;
			end

			if (!ta_ && dbb_ && drtry_)
				report_event("ta_ asserted with neither dbb_ nor drtry_ low");
			if (!ta_ && valid_artry)
				report_event("ta_ asserted in the same cycle as a valid artry_");
			// a global tenure of the data owner holds TA_ back for the snoop window
			if (!ta_ && global_ts && (a_owner == d_owner) && since_ts >= 1 &&
				since_ts < aack_min_delay)
				report_value("ta_ delay after ts_", since_ts, aack_min_delay);

			if (!drtry_ && !prev_ta_low && !prev_drtry_low)
				report_event("drtry_ asserted without a ta_ in the cycle before");
			if (!drtry_ && prev_valid_artry)
				report_value("drtry_ after valid artry_", 32'(drtry_), 1);

			// done is judged before the beat of the previous cycle is credited
			if (cpu1_done || cpu2_done) begin
				done_cpu = cpu1_done ? cpu1 : cpu2;
				if (cpu1_done && cpu2_done)
					report_event("both cpus pulsed done in the same cycle");
				if (!cmd_active || done_cpu != cpu_id_t'(cmd_cpu)) begin
					report_event($sformatf("done from cpu%0d without a pending command",
						done_cpu + 1));
				end else begin
					if (beats[done_cpu] != exp_beats)
						report_value("good beats", beats[done_cpu], exp_beats);
					if (ts_seen[done_cpu] != exp_ts)
						report_value("ts_ count", ts_seen[done_cpu], exp_ts);
				end
				ts_seen[done_cpu] = 0;
			end

			// a beat is good when DRTRY_ stays high in the cycle after TA_
			if (prev_ta_low && prev_dbb_low && drtry_)
				beats[d_owner] = beats[d_owner] + 1;
			if (!dbb_ && !prev_dbb_low)
				beats[d_owner] = 0;

			// owner records move only after this cycle's checks
			if (!ts_)
				a_owner_q = next_a;
			if (!bg1_)
				next_a = cpu1;
			else if (!bg2_)
				next_a = cpu2;
			if (dbb_)
				d_owner = !dbg1_ ? cpu1 : cpu2;
			prev_ta_low = !ta_;
			prev_dbb_low = !dbb_;
			prev_drtry_low = !drtry_;
			prev_valid_artry = valid_artry;
		end
	end

endmodule

`default_nettype wire

// File: test/bus_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bus_tb import bus_pkg::*; ();

	logic clk;
	logic reset;
	logic cpu1_req;
	logic [4:0] cpu1_tt;
	logic cpu1_gbl;
	logic cpu2_req;
	logic [4:0] cpu2_tt;
	logic cpu2_gbl;
	logic artry_;
	wire cpu1_done;
	wire cpu2_done;
	wire ts_;
	wire [4:0] tt;
	wire gbl_;
	wire aack_;
	wire ta_;
	wire drtry_;
	wire dbb_;
	wire bg1_;
	wire bg2_;
	wire dbg1_;
	wire [31:0] chk_errors;

	// what the checker should see when the running command finishes
	logic cmd_active;
	cpu_id_t cmd_cpu;
	logic [4:0] exp_tt;
	logic exp_gbl_;
	int exp_beats;
	int exp_ts;
	int tb_errors;
	int seed;

	bus_top i_bus_top (
		.clk(clk), .reset(reset),
		.cpu1_req(cpu1_req), .cpu1_tt(cpu1_tt), .cpu1_gbl(cpu1_gbl),
		.cpu2_req(cpu2_req), .cpu2_tt(cpu2_tt), .cpu2_gbl(cpu2_gbl),
		.artry_(artry_), .cpu1_done(cpu1_done), .cpu2_done(cpu2_done),
		.ts_(ts_), .tt(tt), .gbl_(gbl_), .aack_(aack_), .ta_(ta_), .drtry_(drtry_),
		.dbb_(dbb_), .bg1_(bg1_), .bg2_(bg2_), .dbg1_(dbg1_)
	);

	bus_checker i_checker (
		.clk(clk), .reset(reset), .ts_(ts_), .tt(tt), .gbl_(gbl_), .aack_(aack_),
		.artry_(artry_), .ta_(ta_), .drtry_(drtry_), .dbb_(dbb_),
		.bg1_(bg1_), .bg2_(bg2_), .dbg1_(dbg1_),
		.cpu1_done(cpu1_done), .cpu2_done(cpu2_done),
		.cmd_active(cmd_active), .cmd_cpu(cmd_cpu),
		.exp_tt(exp_tt), .exp_gbl_(exp_gbl_),
		.exp_beats(exp_beats), .exp_ts(exp_ts),
		.errors(chk_errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// one command from request to done, entered right after a falling edge
	task automatic run_case(input int cpu, input int tt_val, input int gbl_val,
		input int offset, input int beats, output logic ok);
		int cycles;
		logic seen;
		ok = 1'b1;
		cmd_active = 1'b1;
		cmd_cpu = (cpu == 1) ? cpu1 : cpu2;
		exp_tt = 5'(tt_val);
		// a snoop push goes out with gbl_ high even when the command asks for global
		exp_gbl_ = !(gbl_val[0] && (5'(tt_val) != tt_snoop_push));
		exp_beats = beats;
		// an ARTRY_ inside the tenure costs one more TS_
		exp_ts = (offset >= 0) ? 2 : 1;
		if (cpu == 1) begin
			cpu1_req = 1'b1;
			cpu1_tt = 5'(tt_val);
			cpu1_gbl = gbl_val[0];
		end else begin
			cpu2_req = 1'b1;
			cpu2_tt = 5'(tt_val);
			cpu2_gbl = gbl_val[0];
		end
		@(negedge clk);
		cpu1_req = 1'b0;
		cpu2_req = 1'b0;
		if (offset >= 0) begin
			// TS_ comes one cycle after the grant, so the pulse is timed from the grant
			seen = 1'b0;
			for (cycles = 0; cycles < 100 && !seen; cycles++) begin
				@(negedge clk);
				seen = (cpu == 1) ? !bg1_ : !bg2_;
			end
			if (!seen) begin
				$display("timeout: cpu%0d was never granted the address bus", cpu);
				ok = 1'b0;
			end else begin
				repeat (offset + 1) @(negedge clk);
				artry_ = 1'b0;
				@(negedge clk);
				artry_ = 1'b1;
			end
		end
		if (ok) begin
			seen = 1'b0;
			for (cycles = 0; cycles < 2000 && !seen; cycles++) begin
				@(negedge clk);
				seen = (cpu == 1) ? cpu1_done : cpu2_done;
			end
			if (!seen) begin
				$display("timeout: cpu%0d never signalled done", cpu);
				ok = 1'b0;
			end
		end
		@(negedge clk);
		cmd_active = 1'b0;
	endtask

	initial begin
		int fd;
		int n;
		int cpu;
		int tt_val;
		int gbl_val;
		int offset;
		int beats;
		int gap;
		int cases_run;
		logic ok;
		logic stop;
		string line;
		seed = 32'hdacc_fa6f;
		tb_errors = 0;
		cases_run = 0;
		stop = 1'b0;
		reset = 1'b1;
		cpu1_req = 1'b0;
		cpu1_tt = 5'd0;
		cpu1_gbl = 1'b0;
		cpu2_req = 1'b0;
		cpu2_tt = 5'd0;
		cpu2_gbl = 1'b0;
		artry_ = 1'b1;
		cmd_active = 1'b0;
		cmd_cpu = cpu1;
		exp_tt = 5'd0;
		exp_gbl_ = 1'b1;
		exp_beats = 0;
		exp_ts = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		fd = $fopen("test/bus_cases.txt", "r");
		if (fd == 0) begin
			$display("error: the cases file test/bus_cases.txt could not be opened");
			tb_errors++;
			stop = 1'b1;
		end
		while (!stop && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n <= 0 || line.len() < 2 || line.getc(0) == "#")
				continue;
			n = $sscanf(line, "%d %h %d %d %d", cpu, tt_val, gbl_val, offset, beats);
			if (n != 5 || (cpu != 1 && cpu != 2)) begin
				$display("error: a line of the cases file could not be read: %s", line);
				tb_errors++;
				continue;
			end
			// random idle time between commands
			gap = $unsigned($random(seed)) % 6;
			repeat (gap + 1) @(negedge clk);
			run_case(cpu, tt_val, gbl_val, offset, beats, ok);
			cases_run++;
			if (!ok) begin
				tb_errors++;
				stop = 1'b1;
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (cases_run == 0) begin
			$display("error: no command was run from the cases file");
			tb_errors++;
		end
		repeat (4) @(negedge clk);

		$display("errors: checker %0d, testbench %0d", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
src/bus_pkg.sv
src/choice_lfsr.sv
src/bus_arbiter.sv
src/bus_master.sv
src/mem_target.sv
src/bus_top.sv
test/bus_checker.sv
test/bus_tb.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build bus_tb with Verilator, run it and search the log for the pass line"
	@echo "  clean  remove the Verilator build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module bus_tb -Mdir obj_dir -f sim.f
	./obj_dir/Vbus_tb | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/bus_cases.txt
# cpu tt(hex) global artry_offset beats
# artry_offset counts cycles after the TS_ cycle, -1 means no ARTRY_
1 0a 1 -1 4
2 0a 1 -1 4
1 02 0 -1 4
2 06 1 -1 4
1 0a 1 1 4
2 02 1 0 4
1 06 1 -1 4
2 0a 0 3 4
1 0a 1 2 4
2 0a 1 -1 4
